// ==== all.f ====
verilog/bus_pkg.sv
verilog/dev_pkg.sv
verilog/mmu.sv
verilog/storage_controller.sv
verilog/gpio_bank.sv
verilog/interval_timer.sv
verilog/mem_subsystem.sv
tb/spi_flash_model.sv
tb/mmu_asserts.sv
tb/mem_subsystem_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module mem_subsystem_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vmem_subsystem_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/10ps

module mem_subsystem_tb;
    import bus_pkg::*;
    import dev_pkg::*;

    // Flash read takes 64 bits of two SCK halves each plus overhead
    localparam int FLASH_CYC = 16 + 64 * 2 * SPI_DIV;
    localparam int REQ_CYC   = 8;
    localparam int CYCLE_LIMIT = 240 * REQ_CYC + 12 * FLASH_CYC + 1100 + 500;

    logic                clk;
    logic                rst;
    logic                req_valid;
    bus_req_t            req;
    logic                credit;
    logic                rsp_valid;
    bus_rsp_t            rsp;
    logic                cs_n;
    logic                sck;
    logic                mosi;
    logic                miso;
    logic [GPIO_N-1:0]   gpio_in;
    logic [GPIO_N-1:0]   gpio_out;
    logic [GPIO_N-1:0]   gpio_oe;

    logic [31:0]         seed;
    int                  credits;
    int                  err_count;
    int                  check_count;
    int                  cycles;
    int                  test_errs;
    string               test_name;
    bus_rsp_t            exp_q[$];
    logic [31:0]         exp_addr_q[$];

    logic [DATA_W-1:0]   sram_mirror [SRAM_WORDS];
    int                  sram_used[$];
    logic [GPIO_N-1:0]   dir_mirror;
    logic [GPIO_N-1:0]   out_mirror;

    mem_subsystem mem_subsystem_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .credit_o     (credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp),
        .flash_cs_n_o (cs_n),
        .flash_sck_o  (sck),
        .flash_mosi_o (mosi),
        .flash_miso_i (miso),
        .gpio_in_i    (gpio_in),
        .gpio_out_o   (gpio_out),
        .gpio_oe_o    (gpio_oe)
    );

    spi_flash_model spi_flash_model_inst (
        .cs_n_i (cs_n),
        .sck_i  (sck),
        .mosi_i (mosi),
        .miso_o (miso)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Four bytes from the word-aligned byte address with the first byte low
    function automatic logic [31:0] flash_word(input logic [31:0] addr);
        logic [23:0] base;
        logic [31:0] w;
        base = {addr[23:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = (base[7:0] + 8'(i)) ^ 8'hA5;
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_count++;
        if (exp_v !== act_v) begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, what, exp_v, act_v);
            err_count++;
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same point
    task automatic send(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] be, input logic [31:0] exp_rdata,
                        input logic exp_err);
        bus_rsp_t e;
        while (credits == 0) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        credits--;
        e.rdata = exp_rdata;
        e.err   = exp_err;
        exp_q.push_back(e);
        exp_addr_q.push_back(addr);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic sram_access(input logic we, input int word, input logic [31:0] data,
                               input logic [3:0] be);
        logic [31:0] addr;
        addr = SRAM_BASE + 32'(word * 4);
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    sram_mirror[word][8*b +: 8] = data[8*b +: 8];
                end
            end
            send(1'b1, addr, data, be, 32'h0, 1'b0);
        end else begin
            send(1'b0, addr, 32'h0, 4'h0, sram_mirror[word], 1'b0);
        end
    endtask

    task automatic gpio_val_read(input int i);
        if (dir_mirror[i]) begin
            send(1'b0, GPIO_VAL_BASE + 32'(i), 32'h0, 4'h0, 32'(gpio_in[i]), 1'b0);
        end else begin
            send(1'b0, GPIO_VAL_BASE + 32'(i), 32'h0, 4'h0, 32'h0, 1'b1);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        drain();
        $display("test %s: %0d mismatches", test_name, err_count - test_errs);
    endtask

    // Responses and credits are sampled away from the rising edge
    always @(negedge clk) begin
        bus_rsp_t    e;
        logic [31:0] a;
        if (rst) begin
            if (credit) begin
                credits++;
                if (credits > REQ_CREDITS) begin
                    $display("credit count rose above %0d at %0t", REQ_CREDITS, $time);
                    err_count++;
                end
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response without a request at %0t", $time);
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    a = exp_addr_q.pop_front();
                    check_value($sformatf("rdata @%h", a), e.rdata, rsp.rdata);
                    check_value($sformatf("err @%h", a), 32'(e.err), 32'(rsp.err));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d responses missing",
                     cycles, exp_q.size());
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int          word;
        int          sel;
        int          flash_budget;
        logic [31:0] r;
        logic [31:0] addr;
        logic        bit_v;

        seed        = 32'h5846;
        rst         = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        gpio_in     = '0;
        credits     = REQ_CREDITS;
        err_count   = 0;
        check_count = 0;
        cycles      = 0;
        dir_mirror  = '1;
        out_mirror  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        begin_test("sram");
        for (int i = 0; i < 40; i++) begin
            word = i * 25 + int'(next_rand() % 25);
            sram_used.push_back(word);
            sram_access(1'b1, word, next_rand(), 4'hF);
            r = next_rand();
            sram_access(1'b1, word, next_rand(), r[3:0]);
        end
        foreach (sram_used[i]) begin
            sram_access(1'b0, sram_used[i], 32'h0, 4'h0);
        end
        end_test();

        begin_test("flash");
        for (int i = 0; i < 8; i++) begin
            addr = FLASH_BASE + (next_rand() % 32'h00FF_0000);
            if (i == 5) begin
                send(1'b1, addr, next_rand(), 4'hF, 32'h0, 1'b1);
            end else begin
                send(1'b0, addr, 32'h0, 4'h0, flash_word(addr), 1'b0);
            end
        end
        end_test();

        begin_test("gpio");
        for (int i = 0; i < GPIO_N; i++) begin
            bit_v         = next_rand() & 1;
            dir_mirror[i] = bit_v;
            send(1'b1, GPIO_DIR_BASE + 32'(i), 32'(bit_v), 4'hF, 32'h0, 1'b0);
        end
        for (int i = 0; i < GPIO_N; i++) begin
            send(1'b0, GPIO_DIR_BASE + 32'(i), 32'h0, 4'h0, 32'(dir_mirror[i]), 1'b0);
        end
        drain();
        check_value("gpio_oe", 32'(dir_mirror ^ {GPIO_N{1'b1}}), 32'(gpio_oe));
        for (int i = 0; i < GPIO_N; i++) begin
            bit_v = next_rand() & 1;
            if (dir_mirror[i]) begin
                send(1'b1, GPIO_VAL_BASE + 32'(i), 32'(bit_v), 4'hF, 32'h0, 1'b1);
            end else begin
                out_mirror[i] = bit_v;
                send(1'b1, GPIO_VAL_BASE + 32'(i), 32'(bit_v), 4'hF, 32'h0, 1'b0);
            end
        end
        drain();
        check_value("gpio_out", 32'(out_mirror), 32'(gpio_out));
        gpio_in = GPIO_N'(next_rand());
        repeat (4) @(posedge clk);
        #1;
        for (int i = 0; i < GPIO_N; i++) begin
            gpio_val_read(i);
        end
        end_test();

        begin_test("timer");
        send(1'b1, TIMER_ADDR, 32'd1000, 4'hF, 32'h0, 1'b0);
        send(1'b0, TIMER_ADDR, 32'h0, 4'h0, 32'h0, 1'b0);
        drain();
        repeat (1100) @(posedge clk);
        #1;
        send(1'b0, TIMER_ADDR, 32'h0, 4'h0, 32'h1, 1'b0);
        end_test();

        begin_test("reserved");
        for (int i = 0; i < 20; i++) begin
            if (i < 10) begin
                addr = next_rand() % 32'h101;
            end else begin
                addr = 32'h116 + (next_rand() % (32'h1000 - 32'h116));
            end
            r = next_rand();
            send(r[0], addr, r, 4'hF, 32'h0, 1'b1);
        end
        end_test();

        // Mixed traffic without draining between requests
        begin_test("credit");
        flash_budget = 4;
        for (int i = 0; i < 40; i++) begin
            sel  = int'(next_rand() % 8);
            word = sram_used[next_rand() % 40];
            r    = next_rand();
            if (sel < 3) begin
                sram_access(r[4], word, next_rand(), r[3:0]);
            end else if (sel == 3) begin
                send(1'b0, GPIO_DIR_BASE + 32'(r % GPIO_N), 32'h0, 4'h0,
                     32'(dir_mirror[r % GPIO_N]), 1'b0);
            end else if (sel == 5) begin
                send(1'b0, TIMER_ADDR, 32'h0, 4'h0, 32'h1, 1'b0);
            end else if (sel == 6) begin
                gpio_val_read(int'(r % GPIO_N));
            end else if (sel == 7 && flash_budget > 0) begin
                flash_budget--;
                addr = FLASH_BASE + (r % 32'h0010_0000);
                send(1'b0, addr, 32'h0, 4'h0, flash_word(addr), 1'b0);
            end else begin
                send(1'b0, 32'h116 + (r % 32'h0E00), 32'h0, 4'h0, 32'h0, 1'b1);
            end
        end
        end_test();

        $display("checks: %0d, mismatches: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

// ==== tb/mmu_asserts.sv ====
`timescale 1ns/10ps

module mmu_asserts (
    input logic                                      clk,
    input logic                                      rst,
    input logic                                      req_valid_i,
    input logic                                      credit_o,
    input logic                                      rsp_valid_o,
    input logic [$clog2(bus_pkg::REQ_CREDITS+1)-1:0] fifo_cnt
);
    import bus_pkg::*;

    // Credits currently held by the core
    int held_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            held_q <= REQ_CREDITS;
        end else begin
            held_q <= held_q - int'(req_valid_i) + int'(credit_o);
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst)
        held_q <= REQ_CREDITS && held_q >= 0)
        else $error("credit count out of range");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        !(fifo_cnt == REQ_CREDITS && req_valid_i && !credit_o))
        else $error("request queue overflow");

    a_quiet_reset: assert property (@(posedge clk)
        (!rst && $past(!rst)) |-> (!rsp_valid_o && !credit_o))
        else $error("activity during reset");

endmodule : mmu_asserts

bind mmu mmu_asserts mmu_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .credit_o    (credit_o),
    .rsp_valid_o (rsp_valid_o),
    .fifo_cnt    (fifo_cnt_q)
);

// ==== tb/spi_flash_model.sv ====
`timescale 1ns/10ps

module spi_flash_model (
    input  logic cs_n_i,
    input  logic sck_i,
    input  logic mosi_i,
    output logic miso_o
);
    import dev_pkg::*;

    logic [31:0] in_sr;
    logic [23:0] addr_q;
    logic [23:0] byte_addr;
    logic [7:0]  byte_val;
    logic        cmd_ok;
    int          rise_cnt;
    int          k;

    initial begin
        miso_o   = 1'b0;
        cmd_ok   = 1'b0;
        rise_cnt = 0;
    end

    // New transaction starts when chip select falls
    always @(negedge cs_n_i) begin
        rise_cnt = 0;
        cmd_ok   = 1'b0;
        miso_o   = 1'b0;
    end

    // Opcode and address arrive MSB first on rising SCK
    always @(posedge sck_i) begin
        if (!cs_n_i) begin
            in_sr = {in_sr[30:0], mosi_i};
            rise_cnt++;
            if (rise_cnt == 8) begin
                cmd_ok = (in_sr[7:0] == FLASH_READ);
                if (!cmd_ok) begin
                    $display("flash model: unexpected opcode %h at %0t", in_sr[7:0], $time);
                end
            end
            if (rise_cnt == 32) begin
                addr_q = in_sr[23:0];
            end
        end
    end

    // Data bits change on falling SCK ahead of the next rising edge
    always @(negedge sck_i) begin
        if (!cs_n_i && rise_cnt >= 32) begin
            k         = rise_cnt - 32;
            byte_addr = addr_q + 24'(k / 8);
            byte_val  = byte_addr[7:0] ^ 8'hA5;
            miso_o    = cmd_ok ? byte_val[7 - (k % 8)] : 1'b0;
        end
    end

endmodule : spi_flash_model

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  bus_pkg::bus_req_t          req_i,
    output logic                       credit_o,
    output logic                       rsp_valid_o,
    output bus_pkg::bus_rsp_t          rsp_o,
    output logic                       flash_cs_n_o,
    output logic                       flash_sck_o,
    output logic                       flash_mosi_o,
    input  logic                       flash_miso_i,
    input  logic [bus_pkg::GPIO_N-1:0] gpio_in_i,
    output logic [bus_pkg::GPIO_N-1:0] gpio_out_o,
    output logic [bus_pkg::GPIO_N-1:0] gpio_oe_o
);
    import bus_pkg::*;
    import dev_pkg::*;

    logic               stor_start;
    storage_cmd_t       stor_cmd;
    logic               stor_done;
    logic [DATA_W-1:0]  stor_rdata;

    logic               gpio_access;
    logic               gpio_we;
    logic               gpio_dir_sel;
    logic [GPIO_IW-1:0] gpio_idx;
    logic               gpio_wbit;
    logic               gpio_rbit;
    logic               gpio_err;

    logic               timer_load;
    logic [TIMER_W-1:0] timer_val;
    logic               timer_expired;

    mmu mmu_inst (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .credit_o        (credit_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .stor_start_o    (stor_start),
        .stor_cmd_o      (stor_cmd),
        .stor_done_i     (stor_done),
        .stor_rdata_i    (stor_rdata),
        .gpio_access_o   (gpio_access),
        .gpio_we_o       (gpio_we),
        .gpio_dir_sel_o  (gpio_dir_sel),
        .gpio_idx_o      (gpio_idx),
        .gpio_wbit_o     (gpio_wbit),
        .gpio_rbit_i     (gpio_rbit),
        .gpio_err_i      (gpio_err),
        .timer_load_o    (timer_load),
        .timer_val_o     (timer_val),
        .timer_expired_i (timer_expired)
    );

    storage_controller storage_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .start_i      (stor_start),
        .cmd_i        (stor_cmd),
        .done_o       (stor_done),
        .rdata_o      (stor_rdata),
        .flash_cs_n_o (flash_cs_n_o),
        .flash_sck_o  (flash_sck_o),
        .flash_mosi_o (flash_mosi_o),
        .flash_miso_i (flash_miso_i)
    );

    gpio_bank gpio_bank_inst (
        .clk       (clk),
        .rst       (rst),
        .access_i  (gpio_access),
        .we_i      (gpio_we),
        .dir_sel_i (gpio_dir_sel),
        .idx_i     (gpio_idx),
        .wbit_i    (gpio_wbit),
        .rbit_o    (gpio_rbit),
        .err_o     (gpio_err),
        .pin_in_i  (gpio_in_i),
        .pin_out_o (gpio_out_o),
        .pin_oe_o  (gpio_oe_o)
    );

    interval_timer interval_timer_inst (
        .clk        (clk),
        .rst        (rst),
        .load_i     (timer_load),
        .load_val_i (timer_val),
        .expired_o  (timer_expired)
    );

endmodule : mem_subsystem

// ==== verilog/interval_timer.sv ====
`timescale 1ns/10ps

module interval_timer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_i,
    input  logic [dev_pkg::TIMER_W-1:0] load_val_i,
    output logic                        expired_o
);
    import dev_pkg::*;

    logic [TIMER_W-1:0] count_q;

    // Counts down once per clock and parks at zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_val_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign expired_o = (count_q == '0);

endmodule : interval_timer

// ==== verilog/gpio_bank.sv ====
`timescale 1ns/10ps

module gpio_bank (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        access_i,
    input  logic                        we_i,
    input  logic                        dir_sel_i,
    input  logic [bus_pkg::GPIO_IW-1:0] idx_i,
    input  logic                        wbit_i,
    output logic                        rbit_o,
    output logic                        err_o,
    input  logic [bus_pkg::GPIO_N-1:0]  pin_in_i,
    output logic [bus_pkg::GPIO_N-1:0]  pin_out_o,
    output logic [bus_pkg::GPIO_N-1:0]  pin_oe_o
);
    import bus_pkg::*;

    // Direction 1 is input
    logic [GPIO_N-1:0] dir_q;
    logic [GPIO_N-1:0] out_q;
    logic [GPIO_N-1:0] sync1_q;
    logic [GPIO_N-1:0] sync2_q;

    // Value writes need an output pin, value reads an input pin
    assign err_o  = access_i && !dir_sel_i && (we_i ? dir_q[idx_i] : !dir_q[idx_i]);
    assign rbit_o = dir_sel_i ? dir_q[idx_i] : sync2_q[idx_i];

    always_ff @(posedge clk) begin
        if (!rst) begin
            dir_q <= '1;
            out_q <= '0;
        end else if (access_i && we_i && !err_o) begin
            if (dir_sel_i) begin
                dir_q[idx_i] <= wbit_i;
            end else begin
                out_q[idx_i] <= wbit_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        sync1_q <= pin_in_i;
        sync2_q <= sync1_q;
    end

    assign pin_out_o = out_q;
    assign pin_oe_o  = ~dir_q;

endmodule : gpio_bank

// ==== verilog/storage_controller.sv ====
`timescale 1ns/10ps

module storage_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  bus_pkg::storage_cmd_t      cmd_i,
    output logic                       done_o,
    output logic [bus_pkg::DATA_W-1:0] rdata_o,
    output logic                       flash_cs_n_o,
    output logic                       flash_sck_o,
    output logic                       flash_mosi_o,
    input  logic                       flash_miso_i
);
    import bus_pkg::*;
    import dev_pkg::*;

    logic [DATA_W-1:0] sram [SRAM_WORDS];
    logic [DATA_W-1:0] sram_q;
    logic              sram_done_q;
    logic              sram_go;
    logic              flash_go;

    flash_state_e               fl_state_q;
    logic [$clog2(SPI_DIV)-1:0] div_cnt_q;
    logic                       tick;
    logic [5:0]                 bit_cnt_q;
    logic [DATA_W-1:0]          tx_sr_q;
    logic [DATA_W-1:0]          rx_sr_q;
    logic                       cs_n_q;
    logic                       sck_q;

    assign sram_go  = start_i && !cmd_i.flash;
    assign flash_go = start_i && cmd_i.flash;

    // Scratch array, one cycle to read
    always_ff @(posedge clk) begin
        if (sram_go) begin
            if (cmd_i.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (cmd_i.be[b]) begin
                        sram[cmd_i.waddr[SRAM_AW-1:0]][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
                    end
                end
            end
            sram_q <= sram[cmd_i.waddr[SRAM_AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            sram_done_q <= 1'b0;
        end else begin
            sram_done_q <= sram_go;
        end
    end

    assign tick = (div_cnt_q == SPI_DIV - 1);

    // SPI mode 0 read: MOSI shifts on falling SCK, MISO sampled on rising SCK
    always_ff @(posedge clk) begin
        if (!rst) begin
            fl_state_q <= FL_IDLE;
            cs_n_q     <= 1'b1;
            sck_q      <= 1'b0;
            div_cnt_q  <= '0;
            bit_cnt_q  <= '0;
            tx_sr_q    <= '0;
        end else begin
            case (fl_state_q)
                FL_IDLE: begin
                    if (flash_go) begin
                        fl_state_q <= FL_CMD;
                        cs_n_q     <= 1'b0;
                        div_cnt_q  <= '0;
                        bit_cnt_q  <= 6'd7;
                        tx_sr_q    <= {FLASH_READ, cmd_i.waddr[FLASH_AW-3:0], 2'b00};
                    end
                end
                FL_CMD, FL_ADDR, FL_DATA: begin
                    div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
                    if (tick) begin
                        sck_q <= !sck_q;
                        if (!sck_q) begin
                            if (fl_state_q == FL_DATA) begin
                                rx_sr_q <= {rx_sr_q[DATA_W-2:0], flash_miso_i};
                            end
                        end else begin
                            tx_sr_q <= {tx_sr_q[DATA_W-2:0], 1'b0};
                            if (bit_cnt_q != '0) begin
                                bit_cnt_q <= bit_cnt_q - 1'b1;
                            end else if (fl_state_q == FL_CMD) begin
                                fl_state_q <= FL_ADDR;
                                bit_cnt_q  <= 6'(FLASH_AW - 1);
                            end else if (fl_state_q == FL_ADDR) begin
                                fl_state_q <= FL_DATA;
                                bit_cnt_q  <= 6'(DATA_W - 1);
                            end else begin
                                fl_state_q <= FL_DONE;
                                cs_n_q     <= 1'b1;
                            end
                        end
                    end
                end
                FL_DONE: fl_state_q <= FL_IDLE;
                default: fl_state_q <= FL_IDLE;
            endcase
        end
    end

    assign flash_cs_n_o = cs_n_q;
    assign flash_sck_o  = sck_q;
    assign flash_mosi_o = tx_sr_q[DATA_W-1];

    assign done_o = sram_done_q || (fl_state_q == FL_DONE);

    // First byte received lands in the low byte
    assign rdata_o = (fl_state_q == FL_DONE)
                   ? {rx_sr_q[7:0], rx_sr_q[15:8], rx_sr_q[23:16], rx_sr_q[31:24]}
                   : sram_q;

endmodule : storage_controller

// ==== verilog/mmu.sv ====
`timescale 1ns/10ps

module mmu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid_i,
    input  bus_pkg::bus_req_t           req_i,
    output logic                        credit_o,
    output logic                        rsp_valid_o,
    output bus_pkg::bus_rsp_t           rsp_o,
    output logic                        stor_start_o,
    output bus_pkg::storage_cmd_t       stor_cmd_o,
    input  logic                        stor_done_i,
    input  logic [bus_pkg::DATA_W-1:0]  stor_rdata_i,
    output logic                        gpio_access_o,
    output logic                        gpio_we_o,
    output logic                        gpio_dir_sel_o,
    output logic [bus_pkg::GPIO_IW-1:0] gpio_idx_o,
    output logic                        gpio_wbit_o,
    input  logic                        gpio_rbit_i,
    input  logic                        gpio_err_i,
    output logic                        timer_load_o,
    output logic [dev_pkg::TIMER_W-1:0] timer_val_o,
    input  logic                        timer_expired_i
);
    import bus_pkg::*;
    import dev_pkg::*;

    bus_req_t                         fifo_q [REQ_CREDITS];
    logic [$clog2(REQ_CREDITS)-1:0]   wr_ptr_q;
    logic [$clog2(REQ_CREDITS)-1:0]   rd_ptr_q;
    logic [$clog2(REQ_CREDITS+1)-1:0] fifo_cnt_q;
    logic                             push;
    logic                             pop;

    bus_req_t          cur_q;
    region_e           head_region;
    region_e           region_q;
    mmu_state_e        state_q;
    logic              stor_start_q;
    bus_rsp_t          reg_rsp;
    bus_rsp_t          rsp_q;
    logic [ADDR_W-1:0] gpio_off;

    function automatic region_e decode(input logic [ADDR_W-1:0] addr);
        if (addr >= GPIO_DIR_BASE && addr < GPIO_DIR_BASE + GPIO_N) begin
            return REGION_GPIO_DIR;
        end else if (addr >= GPIO_VAL_BASE && addr < GPIO_VAL_BASE + GPIO_N) begin
            return REGION_GPIO_VAL;
        end else if (addr == TIMER_ADDR) begin
            return REGION_TIMER;
        end else if (addr >= SRAM_BASE && addr <= SRAM_LAST) begin
            return REGION_SRAM;
        end else if (addr >= FLASH_BASE) begin
            return REGION_FLASH;
        end
        return REGION_RESERVED;
    endfunction

    // The core only sends while holding a credit, so a push always finds room
    assign push     = req_valid_i;
    assign pop      = (state_q == MMU_IDLE) && (fifo_cnt_q != '0);
    assign credit_o = pop;

    assign head_region = decode(fifo_q[rd_ptr_q].addr);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fifo_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                fifo_cnt_q <= fifo_cnt_q + 1'b1;
            end else if (pop && !push) begin
                fifo_cnt_q <= fifo_cnt_q - 1'b1;
            end
        end
    end

    // Dispatch FSM handles one request at a time
    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q      <= MMU_IDLE;
            stor_start_q <= 1'b0;
        end else begin
            stor_start_q <= 1'b0;
            case (state_q)
                MMU_IDLE: begin
                    if (pop) begin
                        // Flash writes fall through to the register path as errors
                        if (head_region == REGION_SRAM ||
                            (head_region == REGION_FLASH && !fifo_q[rd_ptr_q].we)) begin
                            state_q      <= MMU_STORAGE;
                            stor_start_q <= 1'b1;
                        end else begin
                            state_q <= MMU_REG;
                        end
                    end
                end
                MMU_REG: state_q <= MMU_RESPOND;
                MMU_STORAGE: begin
                    if (stor_done_i) begin
                        state_q <= MMU_RESPOND;
                    end
                end
                MMU_RESPOND: state_q <= MMU_IDLE;
                default: state_q <= MMU_IDLE;
            endcase
        end
    end

    // Request in service and the response stage
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_q    <= fifo_q[rd_ptr_q];
            region_q <= head_region;
        end
        if (state_q == MMU_REG) begin
            rsp_q <= reg_rsp;
        end else if (state_q == MMU_STORAGE && stor_done_i) begin
            rsp_q.rdata <= cur_q.we ? '0 : stor_rdata_i;
            rsp_q.err   <= 1'b0;
        end
    end

    always_comb begin
        reg_rsp = '0;
        case (region_q)
            REGION_GPIO_DIR, REGION_GPIO_VAL: begin
                reg_rsp.err      = gpio_err_i;
                reg_rsp.rdata[0] = !cur_q.we && !gpio_err_i && gpio_rbit_i;
            end
            REGION_TIMER: reg_rsp.rdata[0] = !cur_q.we && timer_expired_i;
            // Reserved space and flash writes
            default: reg_rsp.err = 1'b1;
        endcase
    end

    assign rsp_valid_o = (state_q == MMU_RESPOND);
    assign rsp_o       = rsp_q;

    // Storage command stays stable for the whole access
    assign stor_start_o     = stor_start_q;
    assign stor_cmd_o.flash = (region_q == REGION_FLASH);
    assign stor_cmd_o.we    = cur_q.we;
    // SRAM uses only the low word address bits
    assign stor_cmd_o.waddr = cur_q.addr[STOR_AW+1:2];
    assign stor_cmd_o.wdata = cur_q.wdata;
    assign stor_cmd_o.be    = cur_q.be;

    assign gpio_dir_sel_o = (region_q == REGION_GPIO_DIR);
    assign gpio_access_o  = (state_q == MMU_REG) &&
                            (gpio_dir_sel_o || region_q == REGION_GPIO_VAL);
    assign gpio_we_o      = cur_q.we;
    assign gpio_off       = cur_q.addr - (gpio_dir_sel_o ? GPIO_DIR_BASE : GPIO_VAL_BASE);
    assign gpio_idx_o     = gpio_off[GPIO_IW-1:0];
    assign gpio_wbit_o    = cur_q.wdata[0];

    assign timer_load_o = (state_q == MMU_REG) && (region_q == REGION_TIMER) && cur_q.we;
    assign timer_val_o  = cur_q.wdata;

endmodule : mmu

// ==== verilog/dev_pkg.sv ====
package dev_pkg;

    typedef enum logic [2:0] {
        REGION_RESERVED,
        REGION_GPIO_DIR,
        REGION_GPIO_VAL,
        REGION_TIMER,
        REGION_SRAM,
        REGION_FLASH
    } region_e;

    typedef enum logic [1:0] {
        MMU_IDLE,
        MMU_REG,
        MMU_STORAGE,
        MMU_RESPOND
    } mmu_state_e;

    typedef enum logic [2:0] {
        FL_IDLE,
        FL_CMD,
        FL_ADDR,
        FL_DATA,
        FL_DONE
    } flash_state_e;

    typedef enum logic [7:0] {
        FLASH_READ = 8'h03
    } flash_cmd_e;

    // SCK half period in clocks
    localparam int SPI_DIV = 2;
    // Byte address bits sent after the opcode
    localparam int FLASH_AW = 24;

    localparam int TIMER_W = 32;

endpackage : dev_pkg

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // Credits held by the core after reset, equal to the queue depth
    localparam int REQ_CREDITS = 2;

    localparam int GPIO_N  = 10;
    localparam int GPIO_IW = $clog2(GPIO_N);

    // Address map, each GPIO block spans GPIO_N addresses
    localparam logic [ADDR_W-1:0] GPIO_DIR_BASE = 32'h0000_0101;
    localparam logic [ADDR_W-1:0] GPIO_VAL_BASE = 32'h0000_010B;
    localparam logic [ADDR_W-1:0] TIMER_ADDR    = 32'h0000_0115;
    localparam logic [ADDR_W-1:0] SRAM_BASE     = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] SRAM_LAST     = 32'h0000_1FFF;
    localparam logic [ADDR_W-1:0] FLASH_BASE    = 32'h0000_2000;

    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_AW    = $clog2(SRAM_WORDS);

    // Word address carried by a storage command
    localparam int STOR_AW = 24;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } bus_rsp_t;

    typedef struct packed {
        logic               flash;
        logic               we;
        logic [STOR_AW-1:0] waddr;
        logic [DATA_W-1:0]  wdata;
        logic [BE_W-1:0]    be;
    } storage_cmd_t;

endpackage : bus_pkg
